// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = uart_tb
FILELIST = sim.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/uart_cfg.svh
// UART configuration constants
// widths, FIFO depth, frame lengths, register offsets and control-bit positions
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

`define UART_DATA_W     8   // character width
`define UART_BAUD_W     10  // baud divisor width
`define UART_PRSC_W     3   // prescaler select width
`define UART_CLKGEN_W   8   // tick vector from clock generator
`define UART_FIFO_DEPTH 4   // power of two, min 2
`define UART_TX_BITS    11  // start + 8 data + stop + pause
`define UART_RX_BITS    10  // start + 8 data + stop
`define UART_ADDR_W     4   // bus address width
`define UART_CTRL_OFFS  0   // control / status register
`define UART_DATA_OFFS  4   // TX push / RX pop

// ---------------------------------------------------------------------------
// control register bits
// ---------------------------------------------------------------------------
`define UART_CTRL_EN            0   // r/w
`define UART_CTRL_PRSC_LSB      3   // r/w, 3 bits
`define UART_CTRL_BAUD_LSB      6   // r/w, 10 bits
`define UART_CTRL_RX_NEMPTY     16  // r/-
`define UART_CTRL_RX_FULL       18  // r/-
`define UART_CTRL_TX_EMPTY      19  // r/-
`define UART_CTRL_TX_FULL       21  // r/-
`define UART_CTRL_IRQ_RX_NEMPTY 22  // r/w
`define UART_CTRL_IRQ_RX_FULL   24  // r/w
`define UART_CTRL_IRQ_TX_EMPTY  25  // r/w
`define UART_CTRL_RX_OVER       30  // r/-, cleared by data read
`define UART_CTRL_TX_BUSY       31  // r/-

`endif

// File: hw/uart_fifo.sv
// UART byte FIFO
// power-of-two circular buffer, registered read data, sync clear
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_fifo
    import uart_pkg::*;
#(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  wire logic            clk_i,
    input  wire logic            rstn_i,
    input  wire logic            clear_i,  // sync clear, high active
    input  wire logic            we_i,
    input  wire uart_data_t      wdata_i,
    input  wire logic            re_i,
    output      uart_data_t      rdata_o,
    output      uart_fifo_stat_t stat_o
);

    localparam int AW = $clog2(DEPTH);

    uart_data_t  mem [DEPTH];
    logic [AW:0] wptr, rptr; // msb is the wrap bit
    logic        full, empty;
    logic        do_we, do_re;

    assign empty = (wptr == rptr);
    assign full  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);
    assign do_we = we_i && !full && !clear_i;  // drop on full
    assign do_re = re_i && !empty && !clear_i; // ignore on empty

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wptr <= '0;
            rptr <= '0;
        end else if (clear_i) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_we) begin
                wptr <= wptr + 1'b1;
            end
            if (do_re) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_we) begin
            mem[wptr[AW-1:0]] <= wdata_i;
        end
        if (do_re) begin
            rdata_o <= mem[rptr[AW-1:0]]; // valid the cycle after re_i
        end
    end

    assign stat_o.avail = !empty;
    assign stat_o.free  = !full;

endmodule

`default_nettype wire

// File: hw/uart_pkg.sv
// UART shared types
// vector typedefs, configuration and FIFO status structs, engine FSM states
`default_nettype none

`include "uart_cfg.svh"

package uart_pkg;

    typedef logic [`UART_DATA_W-1:0] uart_data_t;   // one character
    typedef logic [`UART_BAUD_W-1:0] uart_baud_t;   // baud divisor
    typedef logic [`UART_PRSC_W-1:0] uart_prsc_t;   // tick select
    typedef logic [3:0]              uart_bitcnt_t; // bits left in frame
    typedef logic [31:0]             uart_word_t;   // bus word

    // registered configuration, 17 bits
    typedef struct packed {
        logic       enable;
        uart_prsc_t prsc;
        uart_baud_t baud;
        logic       irq_rx_nempty;
        logic       irq_rx_full;
        logic       irq_tx_empty;
    } uart_ctrl_t;

    typedef struct packed {
        logic avail; // at least one entry
        logic free;  // at least one slot
    } uart_fifo_stat_t;

    typedef enum logic [1:0] {TX_IDLE, TX_PREP, TX_SEND} uart_tx_state_e;
    typedef enum logic {RX_IDLE, RX_RECV} uart_rx_state_e;

endpackage

`default_nettype wire

// File: hw/uart_regs.sv
// UART register interface
// offset decode, control register, delayed read path with status word,
// bus acknowledge and registered interrupt levels
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_regs
    import uart_pkg::*;
(
    input  wire logic                    clk_i,
    input  wire logic                    rstn_i,
    input  wire logic [`UART_ADDR_W-1:0] addr_i,
    input  wire logic                    rden_i,
    input  wire logic                    wren_i,
    input  wire uart_word_t              data_i,
    input  wire uart_fifo_stat_t         tx_stat_i,
    input  wire uart_fifo_stat_t         rx_stat_i,
    input  wire uart_data_t              rx_rdata_i,
    input  wire logic                    rx_over_i,
    input  wire logic                    tx_busy_i,
    output      uart_word_t              data_o,
    output      logic                    ack_o,
    output      uart_ctrl_t              ctrl_o,
    output      logic                    tx_we_o,
    output      uart_data_t              tx_wdata_o,
    output      logic                    rx_re_o,
    output      logic                    clkgen_en_o,
    output      logic                    irq_rx_o,
    output      logic                    irq_tx_o
);

    logic       sel_ctrl, sel_data;
    logic       rd_ff;       // any read, one cycle late
    logic       rd_ctrl_ff;
    logic       rd_data_ff;  // data read that actually popped
    uart_word_t status;

    assign sel_ctrl = (addr_i == `UART_ADDR_W'(`UART_CTRL_OFFS));
    assign sel_data = (addr_i == `UART_ADDR_W'(`UART_DATA_OFFS));

    assign tx_we_o     = wren_i && sel_data;   // full FIFO drops it
    assign tx_wdata_o  = data_i[`UART_DATA_W-1:0];
    assign rx_re_o     = rden_i && sel_data;
    assign clkgen_en_o = ctrl_o.enable;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ctrl_o <= '0;
        end else if (wren_i && sel_ctrl) begin
            ctrl_o.enable        <= data_i[`UART_CTRL_EN];
            ctrl_o.prsc          <= data_i[`UART_CTRL_PRSC_LSB +: `UART_PRSC_W];
            ctrl_o.baud          <= data_i[`UART_CTRL_BAUD_LSB +: `UART_BAUD_W];
            ctrl_o.irq_rx_nempty <= data_i[`UART_CTRL_IRQ_RX_NEMPTY];
            ctrl_o.irq_rx_full   <= data_i[`UART_CTRL_IRQ_RX_FULL];
            ctrl_o.irq_tx_empty  <= data_i[`UART_CTRL_IRQ_TX_EMPTY];
        end
    end

    // ------------------------------------------------------------------------
    // status word and read path
    // ------------------------------------------------------------------------
    always_comb begin
        status                                            = '0;
        status[`UART_CTRL_EN]                             = ctrl_o.enable;
        status[`UART_CTRL_PRSC_LSB +: `UART_PRSC_W]       = ctrl_o.prsc;
        status[`UART_CTRL_BAUD_LSB +: `UART_BAUD_W]       = ctrl_o.baud;
        status[`UART_CTRL_RX_NEMPTY]                      = rx_stat_i.avail;
        status[`UART_CTRL_RX_FULL]                        = !rx_stat_i.free;
        status[`UART_CTRL_TX_EMPTY]                       = !tx_stat_i.avail;
        status[`UART_CTRL_TX_FULL]                        = !tx_stat_i.free;
        status[`UART_CTRL_IRQ_RX_NEMPTY]                  = ctrl_o.irq_rx_nempty;
        status[`UART_CTRL_IRQ_RX_FULL]                    = ctrl_o.irq_rx_full;
        status[`UART_CTRL_IRQ_TX_EMPTY]                   = ctrl_o.irq_tx_empty;
        status[`UART_CTRL_RX_OVER]                        = rx_over_i;
        status[`UART_CTRL_TX_BUSY]                        = tx_busy_i;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rd_ff      <= 1'b0;
            rd_ctrl_ff <= 1'b0;
            rd_data_ff <= 1'b0;
            ack_o      <= 1'b0;
            data_o     <= '0;
        end else begin
            rd_ff      <= rden_i;                      // wait for sync FIFO read
            rd_ctrl_ff <= rden_i && sel_ctrl;
            rd_data_ff <= rx_re_o && rx_stat_i.avail;  // empty read returns zero
            ack_o      <= wren_i || rd_ff;
            if (rd_ctrl_ff) begin
                data_o <= status;
            end else if (rd_data_ff) begin
                data_o <= uart_word_t'(rx_rdata_i);
            end else begin
                data_o <= '0;
            end
        end
    end

    // level interrupts, one cycle behind the FIFO flags
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            irq_rx_o <= 1'b0;
            irq_tx_o <= 1'b0;
        end else begin
            irq_rx_o <= ctrl_o.enable && ((ctrl_o.irq_rx_nempty && rx_stat_i.avail) ||
                                          (ctrl_o.irq_rx_full && !rx_stat_i.free));
            irq_tx_o <= ctrl_o.enable && ctrl_o.irq_tx_empty && !tx_stat_i.avail;
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
// UART receive engine
// tick-clocked synchronizer, falling-edge start detect, mid-bit sampling,
// FIFO write at frame end and the RX overrun flag
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_rx
    import uart_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      rstn_i,
    input  wire uart_ctrl_t                ctrl_i,
    input  wire logic [`UART_CLKGEN_W-1:0] clkgen_i,
    input  wire logic                      uart_rxd_i,
    input  wire logic                      rx_re_i,     // data register read
    input  wire uart_fifo_stat_t           fifo_stat_i,
    output      logic                      fifo_we_o,
    output      uart_data_t                fifo_wdata_o,
    output      logic                      over_o
);

    uart_rx_state_e           state;
    uart_baud_t               baudcnt;
    uart_bitcnt_t             bitcnt;
    logic [2:0]               sync;    // [2] newest, [0] oldest
    logic [`UART_RX_BITS-1:0] sreg;
    logic                     tick;
    logic                     sample;

    assign tick   = clkgen_i[ctrl_i.prsc];
    assign sample = tick && (baudcnt == '0);

    // ------------------------------------------------------------------------
    // synchronizer and FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sync <= '1;                               // line idles high
        end else begin
            sync[2] <= uart_rxd_i;
            if (tick) begin
                sync[1] <= sync[2];
                sync[0] <= sync[1];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state     <= RX_IDLE;
            baudcnt   <= '0;
            bitcnt    <= '0;
            fifo_we_o <= 1'b0;
        end else begin
            fifo_we_o <= 1'b0;
            if (!ctrl_i.enable) begin
                state <= RX_IDLE;
            end else if (state == RX_IDLE) begin
                baudcnt <= {1'b0, ctrl_i.baud[`UART_BAUD_W-1:1]}; // half bit to mid
                bitcnt  <= uart_bitcnt_t'(`UART_RX_BITS);
                if (sync[1:0] == 2'b01) begin
                    state <= RX_RECV;                 // falling edge = start
                end
            end else begin
                if (sample) begin
                    baudcnt <= ctrl_i.baud;
                    bitcnt  <= bitcnt - 1'b1;
                end else if (tick) begin
                    baudcnt <= baudcnt - 1'b1;
                end
                if (bitcnt == '0) begin
                    fifo_we_o <= 1'b1;                // frame done
                    state     <= RX_IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state == RX_RECV) && sample) begin
            sreg <= {sync[2], sreg[`UART_RX_BITS-1:1]};
        end
    end

    assign fifo_wdata_o = sreg[8:1]; // drop start and stop

    // overrun, byte lost to a full FIFO
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            over_o <= 1'b0;
        end else if (rx_re_i || !ctrl_i.enable) begin
            over_o <= 1'b0;
        end else if (fifo_we_o && !fifo_stat_i.free) begin
            over_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_top.sv
// UART peripheral top level
// register block, TX and RX FIFOs and the two serial engines
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_top
    import uart_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      rstn_i,
    input  wire logic [`UART_ADDR_W-1:0]   addr_i,
    input  wire logic                      rden_i,
    input  wire logic                      wren_i,
    input  wire uart_word_t                data_i,
    output      uart_word_t                data_o,
    output      logic                      ack_o,
    output      logic                      clkgen_en_o,
    input  wire logic [`UART_CLKGEN_W-1:0] clkgen_i,
    output      logic                      uart_txd_o,
    input  wire logic                      uart_rxd_i,
    output      logic                      irq_rx_o,
    output      logic                      irq_tx_o
);

    uart_ctrl_t      ctrl;
    uart_fifo_stat_t tx_stat, rx_stat;
    uart_data_t      tx_wdata, tx_rdata, rx_wdata, rx_rdata;
    logic            tx_we, tx_re, rx_we, rx_re;
    logic            rx_over, tx_busy;
    logic            fifo_clear;

    assign fifo_clear = !ctrl.enable; // both FIFOs flush while off

    uart_regs u_regs (
        .clk_i, .rstn_i, .addr_i, .rden_i, .wren_i, .data_i,
        .tx_stat_i (tx_stat),  .rx_stat_i  (rx_stat),  .rx_rdata_i (rx_rdata),
        .rx_over_i (rx_over),  .tx_busy_i  (tx_busy),
        .data_o, .ack_o, .ctrl_o (ctrl),
        .tx_we_o   (tx_we),    .tx_wdata_o (tx_wdata), .rx_re_o    (rx_re),
        .clkgen_en_o, .irq_rx_o, .irq_tx_o
    );

    uart_fifo u_tx_fifo (
        .clk_i, .rstn_i, .clear_i (fifo_clear),
        .we_i (tx_we), .wdata_i (tx_wdata), .re_i (tx_re),
        .rdata_o (tx_rdata), .stat_o (tx_stat)
    );

    uart_fifo u_rx_fifo (
        .clk_i, .rstn_i, .clear_i (fifo_clear),
        .we_i (rx_we), .wdata_i (rx_wdata), .re_i (rx_re),
        .rdata_o (rx_rdata), .stat_o (rx_stat)
    );

    uart_tx u_tx (
        .clk_i, .rstn_i, .ctrl_i (ctrl), .clkgen_i,
        .fifo_stat_i (tx_stat), .fifo_rdata_i (tx_rdata),
        .fifo_re_o (tx_re), .busy_o (tx_busy), .uart_txd_o
    );

    uart_rx u_rx (
        .clk_i, .rstn_i, .ctrl_i (ctrl), .clkgen_i, .uart_rxd_i,
        .rx_re_i (rx_re), .fifo_stat_i (rx_stat),
        .fifo_we_o (rx_we), .fifo_wdata_o (rx_wdata), .over_o (rx_over)
    );

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// UART transmit engine
// pops the TX FIFO and shifts out an 8N1 frame plus one pause bit, LSB first
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_tx
    import uart_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      rstn_i,
    input  wire uart_ctrl_t                ctrl_i,
    input  wire logic [`UART_CLKGEN_W-1:0] clkgen_i,
    input  wire uart_fifo_stat_t           fifo_stat_i,
    input  wire uart_data_t                fifo_rdata_i,
    output      logic                      fifo_re_o,
    output      logic                      busy_o,
    output      logic                      uart_txd_o
);

    uart_tx_state_e  state;
    uart_baud_t      baudcnt;
    uart_bitcnt_t    bitcnt;
    logic [8:0]      sreg;     // data & start bit
    logic            tick;
    logic            bit_done;

    assign tick     = clkgen_i[ctrl_i.prsc];          // prescaled clock enable
    assign bit_done = tick && (baudcnt == '0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state   <= TX_IDLE;
            baudcnt <= '0;
            bitcnt  <= '0;
        end else if (!ctrl_i.enable) begin
            state   <= TX_IDLE;                       // forced idle while off
        end else begin
            case (state)
                TX_IDLE: begin
                    baudcnt <= ctrl_i.baud;
                    bitcnt  <= uart_bitcnt_t'(`UART_TX_BITS);
                    if (fifo_stat_i.avail) begin
                        state <= TX_PREP;             // pop issued this cycle
                    end
                end
                TX_PREP: begin
                    state <= TX_SEND;                 // rdata lands in sreg
                end
                TX_SEND: begin
                    if (bit_done) begin
                        baudcnt <= ctrl_i.baud;
                        bitcnt  <= bitcnt - 1'b1;
                    end else if (tick) begin
                        baudcnt <= baudcnt - 1'b1;
                    end
                    if (bitcnt == '0) begin
                        state <= TX_IDLE;             // stop and pause bits sent
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // shift register, ones fill in behind the data for stop/pause
    always_ff @(posedge clk_i) begin
        if (state == TX_PREP) begin
            sreg <= {fifo_rdata_i, 1'b0};
        end else if ((state == TX_SEND) && bit_done) begin
            sreg <= {1'b1, sreg[8:1]};
        end
    end

    assign fifo_re_o  = ctrl_i.enable && (state == TX_IDLE) && fifo_stat_i.avail;
    assign busy_o     = (state != TX_IDLE) || fifo_stat_i.avail;
    assign uart_txd_o = (state == TX_SEND) ? sreg[0] : 1'b1; // idle line high

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_top.sv
sim/uart_properties.sv
sim/uart_tb.sv

// File: sim/uart_cases.txt
# control word (hex), byte sent (hex), byte expected back (hex)
# control: bit 0 enable, bits 5:3 prescaler, bits 15:6 baud, bits 22/24/25 irq enables
000003c1 a5 a5
000003c1 5a 5a
000003c9 00 00
000003c9 ff ff
000007c1 01 01
000007c1 80 80
000001d1 3c 3c
000001d1 c3 c3
004003c1 12 12
004003c9 34 34
020003c1 56 56
020007c1 78 78
024001d1 9a 9a
034003c1 bc bc
014003c9 de de
000003c1 f0 f0

// File: sim/uart_properties.sv
// UART bus and line protocol assertions
// bound to the peripheral top level
`timescale 1ns/10ps
`default_nettype none

module uart_properties (
    input wire logic clk_i,
    input wire logic rstn_i,
    input wire logic wren_i,
    input wire logic ack_o,
    input wire logic clkgen_en_o,   // mirrors the enable bit
    input wire logic uart_txd_o,
    input wire logic irq_rx_o,
    input wire logic irq_tx_o
);

    // write acknowledged on the next cycle
    ack_after_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wren_i |=> ack_o) else $error("write not acknowledged");

    // engine leaves the frame one cycle after enable drops
    txd_idle_off: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !clkgen_en_o ##1 !clkgen_en_o |-> uart_txd_o) else $error("txd low while off");

    irq_low_off: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !clkgen_en_o ##1 !clkgen_en_o |-> !irq_rx_o && !irq_tx_o) else $error("irq while off");

endmodule

bind uart_top uart_properties u_props (
    .clk_i, .rstn_i, .wren_i, .ack_o, .clkgen_en_o, .uart_txd_o, .irq_rx_o, .irq_tx_o
);

`default_nettype wire

// File: sim/uart_tb.sv
// UART peripheral testbench
// TX looped to RX, case file driven loopback, status, overrun, interrupt and disable checks
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_tb
    import uart_pkg::*;
();

    localparam uart_word_t WMASK = (32'h1 << `UART_CTRL_EN) | (32'h7 << `UART_CTRL_PRSC_LSB) |
        (32'h3ff << `UART_CTRL_BAUD_LSB) | (32'h1 << `UART_CTRL_IRQ_RX_NEMPTY) |
        (32'h1 << `UART_CTRL_IRQ_RX_FULL) | (32'h1 << `UART_CTRL_IRQ_TX_EMPTY);
    localparam uart_word_t TX_EMPTY = 32'h1 << `UART_CTRL_TX_EMPTY;
    localparam int         NFILL    = `UART_FIFO_DEPTH + 1;   // one more than the RX FIFO holds

    logic                      clk_i, rstn_i, rden, wren, ack, clkgen_en, txd, irq_rx, irq_tx;
    logic [`UART_ADDR_W-1:0]   addr;
    logic [`UART_CLKGEN_W-1:0] clkgen;
    uart_word_t                wdata, rdata;
    uart_word_t                case_ctrl [$];
    uart_data_t                case_tx [$];
    uart_data_t                case_exp [$];
    int                        errors = 0;
    longint                    cycles = 0;
    longint                    limit  = 0;              // zero until the cases are known

    uart_top u_dut (
        .clk_i, .rstn_i, .addr_i (addr), .rden_i (rden), .wren_i (wren), .data_i (wdata),
        .data_o (rdata), .ack_o (ack), .clkgen_en_o (clkgen_en), .clkgen_i (clkgen),
        .uart_txd_o (txd), .uart_rxd_i (txd), .irq_rx_o (irq_rx), .irq_tx_o (irq_tx)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // free-running tick divider, bit k pulses every 2^(k+1) cycles
    initial begin
        int unsigned div;
        div    = 0;
        clkgen = '0;
        forever begin
            @(posedge clk_i);
            #1;
            div++;
            for (int k = 0; k < `UART_CLKGEN_W; k++) begin
                clkgen[k] = ((div & ((32'h2 << k) - 1)) == ((32'h2 << k) - 1));
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: no end of test after %0d cycles", cycles);
            $display("errors: %0d", errors);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input uart_word_t got, input uart_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // one strobe cycle, then wait for the acknowledge
    task automatic bus_access(input logic wr, input int offs, input uart_word_t d,
                              output uart_word_t q);
        logic done;
        done = 1'b0;
        @(posedge clk_i);
        #1;
        addr  = offs[`UART_ADDR_W-1:0];
        wdata = d;
        wren  = wr;
        rden  = !wr;
        while (!done) begin
            @(posedge clk_i);
            #1;
            wren = 1'b0;
            rden = 1'b0;
            done = ack;
        end
        q = rdata;
    endtask

    task automatic bus_write(input int offs, input uart_word_t d);
        uart_word_t unused;
        bus_access(1'b1, offs, d, unused);
    endtask

    task automatic bus_read(input int offs, output uart_word_t q);
        bus_access(1'b0, offs, '0, q);
    endtask

    task automatic wait_tx_idle();
        uart_word_t st;
        do bus_read(`UART_CTRL_OFFS, st); while (st[`UART_CTRL_TX_BUSY]);
    endtask

    task automatic wait_rx_data();
        uart_word_t st;
        do bus_read(`UART_CTRL_OFFS, st); while (!st[`UART_CTRL_RX_NEMPTY]);
    endtask

    task automatic read_cases();
        int fd, b, e;
        string line;
        uart_word_t c;
        fd = $fopen("sim/uart_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the case file sim/uart_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#" &&
                $sscanf(line, "%h %h %h", c, b, e) == 3) begin
                case_ctrl.push_back(c);
                case_tx.push_back(b[7:0]);
                case_exp.push_back(e[7:0]);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        uart_word_t st, q;
        uart_data_t fill [NFILL];
        longint     maxb;
        void'($urandom(57664));
        {rstn_i, rden, wren} = '0;
        addr  = '0;
        wdata = '0;
        repeat (16) @(posedge clk_i);
        #1 rstn_i = 1'b1;
        read_cases();
        maxb = 0;
        foreach (case_ctrl[i]) begin
            if (case_ctrl[i][`UART_CTRL_BAUD_LSB +: `UART_BAUD_W] > maxb)
                maxb = case_ctrl[i][`UART_CTRL_BAUD_LSB +: `UART_BAUD_W];
        end
        limit = case_ctrl.size() * 11 * (maxb + 1) * 256 + 2000;

        // ------------------------------------------------------------------------
        // loopback cases with control readback and interrupt checks
        // ------------------------------------------------------------------------
        foreach (case_ctrl[i]) begin
            bus_write(`UART_CTRL_OFFS, case_ctrl[i]);
            wait_tx_idle();                              // pause bit of last frame
            bus_read(`UART_CTRL_OFFS, st);
            check_value("ctrl", st, (case_ctrl[i] & WMASK) | TX_EMPTY);
            check_value("clkgen_en_o", clkgen_en, case_ctrl[i][`UART_CTRL_EN]);
            check_value("irq_tx_o", irq_tx, case_ctrl[i][`UART_CTRL_IRQ_TX_EMPTY]);
            check_value("irq_rx_o", irq_rx, 0);
            bus_write(`UART_DATA_OFFS, case_tx[i]);
            wait_rx_data();
            check_value("irq_rx_o", irq_rx, case_ctrl[i][`UART_CTRL_IRQ_RX_NEMPTY]);
            bus_read(`UART_DATA_OFFS, q);
            check_value("rx_data", q, case_exp[i]);
            check_value("irq_rx_o", irq_rx, 0);
        end

        // ------------------------------------------------------------------------
        // overrun, RX full and draining
        // ------------------------------------------------------------------------
        bus_write(`UART_CTRL_OFFS, 32'h010003c1);        // irq on RX full
        wait_tx_idle();
        foreach (fill[i]) begin
            fill[i] = uart_data_t'($urandom);
            bus_write(`UART_DATA_OFFS, fill[i]);
        end
        wait_tx_idle();
        bus_read(`UART_CTRL_OFFS, st);
        check_value("rx_over", st[`UART_CTRL_RX_OVER], 1);
        check_value("rx_full", st[`UART_CTRL_RX_FULL], 1);
        check_value("irq_rx_o", irq_rx, 1);
        for (int i = 0; i < NFILL - 1; i++) begin
            bus_read(`UART_CTRL_OFFS, st);
            check_value("rx_nempty", st[`UART_CTRL_RX_NEMPTY], 1);
            if (i == 1) check_value("rx_over", st[`UART_CTRL_RX_OVER], 0);
            bus_read(`UART_DATA_OFFS, q);
            check_value("rx_data", q, fill[i]);
        end
        bus_read(`UART_CTRL_OFFS, st);
        check_value("rx_nempty", st[`UART_CTRL_RX_NEMPTY], 0);
        check_value("irq_rx_o", irq_rx, 0);

        // ------------------------------------------------------------------------
        // TX full at a slow baud, then disable
        // ------------------------------------------------------------------------
        bus_write(`UART_DATA_OFFS, 32'h5a);              // one byte left in the RX FIFO
        wait_rx_data();
        bus_write(`UART_CTRL_OFFS, 32'h0240fff9);        // prsc 7, baud 1023
        for (int i = 0; i < NFILL; i++) bus_write(`UART_DATA_OFFS, i + 1);
        bus_read(`UART_CTRL_OFFS, st);
        check_value("tx_full", st[`UART_CTRL_TX_FULL], 1);
        check_value("tx_busy", st[`UART_CTRL_TX_BUSY], 1);
        check_value("irq_tx_o", irq_tx, 0);
        check_value("irq_rx_o", irq_rx, 1);
        bus_write(`UART_CTRL_OFFS, 32'h0);
        bus_read(`UART_CTRL_OFFS, st);
        check_value("status", st, TX_EMPTY);
        check_value("clkgen_en_o", clkgen_en, 0);
        check_value("irq_rx_o", irq_rx, 0);
        check_value("irq_tx_o", irq_tx, 0);

        $display("errors: %0d, cases: %0d, cycles: %0d", errors, case_ctrl.size(), cycles);
        if (errors == 0 && case_ctrl.size() > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
